/* Makefile */
# Verilator flow for the nibble register and arithmetic unit

VERILATOR ?= verilator
TOP       ?= saturn_alru_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/alu_pkg.sv */
// Shared types for the nibble register and arithmetic unit.
// Every design module imports this package. The command struct is the
// bit layout of a write to the APB command address. op is in the top bits.
package alu_pkg;

    localparam int NIBBLES = 16;

    typedef logic [3:0]           nibble_t;
    typedef logic [4*NIBBLES-1:0] word_t;
    typedef logic [3:0]           nib_idx_t;   // field bound with 0 as the rightmost nibble
    typedef logic [NIBBLES-1:0]   nib_mask_t;
    typedef logic [1:0]           reg_sel_t;   // A..D
    typedef logic [2:0]           op2_sel_t;   // A..D, constant, zero

    localparam op2_sel_t OP2_CONST = 3'd4;
    localparam word_t    ALL_NINES = 64'h9999_9999_9999_9999;
    localparam word_t    ALL_F     = 64'hffff_ffff_ffff_ffff;

    typedef enum logic [4:0] {
        TFR, ADD, SUB, AND, OR, ANDN,
        SL, SR, SRB, SLC, SRC,
        EQ, NEQ, GT, GTEQ, LT, LTEQ
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        reg_sel_t  src;
        op2_sel_t  op2;
        reg_sel_t  dst;
        nib_idx_t  left;
        nib_idx_t  right;
        logic      write_dst;
        logic      write_carry;
        logic      forced_carry;
        logic      forced_hex;    // run this command in hex even in decimal mode
        logic [7:0] rsvd;
    } alu_cmd_t;

endpackage

/* design/apb_pkg.sv */
// APB bus types and the register map of the unit.
// Imported by the APB controller, the register file and the top level.
package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    localparam apb_addr_t ADDR_CMD      = 8'h00;   // write only
    localparam apb_addr_t ADDR_STATUS   = 8'h04;   // bit 0 carry, bit 1 decimal
    localparam apb_addr_t ADDR_REG_BASE = 8'h10;   // reg n low at +8n, high at +8n+4
    localparam apb_addr_t ADDR_REG_END  = 8'h30;

endpackage

/* design/saturn_alru_top.sv */
// Top level of the APB-mapped nibble register and arithmetic unit.
// Connects the APB controller, register file, operand latch and ALU.
`timescale 1ns/10ps

module saturn_alru_top
    import alu_pkg::*, apb_pkg::*;
(
    input  logic     clk_in,
    input  logic     pull_rstk_in,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o
);
    alu_cmd_t  cmd;
    logic      latch;
    logic      decimal;
    logic      alu_carry;
    logic      wr_en;
    logic      host_wr;
    logic      host_hi;
    reg_sel_t  host_reg;
    reg_sel_t  rd_sel;
    apb_data_t host_data;
    word_t     rd_a;
    word_t     rd_b;
    word_t     src_q;
    word_t     op2_q;
    word_t     alu_q;
    nib_mask_t mask_q;
    nib_idx_t  left_q;
    nib_idx_t  right_q;
    logic      dec_q;

    saturn_apb_ctrl u_ctrl (
        .clk_in       (clk_in),
        .pull_rstk_in (pull_rstk_in),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .cmd_o        (cmd),
        .latch_o      (latch),
        .decimal_o    (decimal),
        .alu_carry_i  (alu_carry),
        .wr_en_o      (wr_en),
        .host_wr_o    (host_wr),
        .host_hi_o    (host_hi),
        .host_reg_o   (host_reg),
        .host_data_o  (host_data),
        .rd_word_i    (rd_a),
        .rd_sel_o     (rd_sel)
    );

    saturn_regfile u_regs (
        .clk_in       (clk_in),
        .pull_rstk_in (pull_rstk_in),
        .rd_a_sel_i   (rd_sel),
        .rd_b_sel_i   (cmd.op2[1:0]),
        .rd_a_o       (rd_a),
        .rd_b_o       (rd_b),
        .wr_en_i      (wr_en),
        .wr_sel_i     (cmd.dst),
        .wr_mask_i    (mask_q),
        .wr_data_i    (alu_q),
        .host_wr_i    (host_wr),
        .host_hi_i    (host_hi),
        .host_reg_i   (host_reg),
        .host_data_i  (host_data)
    );

    saturn_operand_latch u_latch (
        .clk_in     (clk_in),
        .latch_i    (latch),
        .cmd_i      (cmd),
        .decimal_i  (decimal),
        .src_word_i (rd_a),
        .op2_word_i (rd_b),
        .src_o      (src_q),
        .op2_o      (op2_q),
        .mask_o     (mask_q),
        .left_o     (left_q),
        .right_o    (right_q),
        .dec_o      (dec_q)
    );

    saturn_alu u_alu (
        .src_i          (src_q),
        .op2_i          (op2_q),
        .op_i           (cmd.op),
        .dec_i          (dec_q),
        .forced_carry_i (cmd.forced_carry),
        .left_i         (left_q),
        .right_i        (right_q),
        .q_o            (alu_q),
        .carry_o        (alu_carry)
    );

endmodule

/* design/saturn_alu.sv */
// Result and carry select of the unit, combinational on the latched operands.
// Logic ops and shifts work on the whole word; the register file write
// mask keeps the field boundaries.
`timescale 1ns/10ps

module saturn_alu
    import alu_pkg::*;
(
    input  word_t    src_i,
    input  word_t    op2_i,
    input  alu_op_e  op_i,
    input  logic     dec_i,
    input  logic     forced_carry_i,
    input  nib_idx_t left_i,
    input  nib_idx_t right_i,
    output word_t    q_o,
    output logic     carry_o
);
    word_t as_q;
    logic  as_c;
    logic  eq;
    logic  gt;
    logic  lt;

    saturn_bcd_addsub u_addsub (
        .a_i            (src_i),
        .b_i            (op2_i),
        .sub_i          (op_i == SUB),
        .dec_i          (dec_i),
        .forced_carry_i (forced_carry_i),
        .right_i        (right_i),
        .left_i         (left_i),
        .q_o            (as_q),
        .qc_o           (as_c)
    );

    saturn_compare u_cmp (
        .a_i  (src_i),
        .b_i  (op2_i),
        .eq_o (eq),
        .gt_o (gt),
        .lt_o (lt)
    );

    always_comb
    begin
        case (op_i)
            ADD, SUB: q_o = as_q;
            AND:      q_o = src_i & op2_i;
            OR:       q_o = src_i | op2_i;
            ANDN:     q_o = src_i & ~op2_i;
            SL:       q_o = {src_i[59:0], 4'h0};
            SR:       q_o = {4'h0, src_i[63:4]};
            SRB:      q_o = {1'b0, src_i[63:1]};
            SLC:      q_o = {src_i[59:0], src_i[63:60]};
            SRC:      q_o = {src_i[3:0], src_i[63:4]};
            default:  q_o = src_i;   // TFR and compares
        endcase
    end

    always_comb
    begin
        case (op_i)
            ADD, SUB: carry_o = as_c;
            EQ:       carry_o = eq;
            NEQ:      carry_o = ~eq;
            GT:       carry_o = gt;
            GTEQ:     carry_o = gt | eq;
            LT:       carry_o = lt;
            LTEQ:     carry_o = lt | eq;
            default:  carry_o = 1'b0;
        endcase
    end

endmodule

/* design/saturn_apb_ctrl.sv */
// APB slave of the unit. Decodes the register map, holds the carry and
// decimal flags and the command register, and runs the command sequencer.
// A command write is taken in its setup phase; the access phase then sees
// LATCH (operands registered) and WRITE (result and carry committed, pready).
`timescale 1ns/10ps

module saturn_apb_ctrl
    import alu_pkg::*, apb_pkg::*;
(
    input  logic      clk_in,
    input  logic      pull_rstk_in,
    input  apb_req_t  apb_req_i,
    output apb_rsp_t  apb_rsp_o,
    output alu_cmd_t  cmd_o,
    output logic      latch_o,
    output logic      decimal_o,
    input  logic      alu_carry_i,
    output logic      wr_en_o,
    output logic      host_wr_o,
    output logic      host_hi_o,
    output reg_sel_t  host_reg_o,
    output apb_data_t host_data_o,
    input  word_t     rd_word_i,
    output reg_sel_t  rd_sel_o
);
    typedef enum logic [1:0] {IDLE, LATCH, WRITE} seq_state_e;

    seq_state_e state_q;
    alu_cmd_t   cmd_q;
    logic       carry_q;
    logic       decimal_q;
    logic       access;
    logic       hit_cmd_wr;
    logic       hit_status;
    logic       hit_reg;
    logic       cmd_start;
    apb_addr_t  reg_off;

    assign access     = apb_req_i.psel & apb_req_i.penable;
    assign hit_cmd_wr = (apb_req_i.paddr == ADDR_CMD) & apb_req_i.pwrite;
    assign hit_status = apb_req_i.paddr == ADDR_STATUS;
    assign reg_off    = apb_req_i.paddr - ADDR_REG_BASE;
    assign hit_reg    = (apb_req_i.paddr >= ADDR_REG_BASE) && (apb_req_i.paddr < ADDR_REG_END)
                        && (apb_req_i.paddr[1:0] == 2'b00);

    // setup phase of a command write
    assign cmd_start = apb_req_i.psel & ~apb_req_i.penable & hit_cmd_wr & (state_q == IDLE);

    always_ff @(posedge clk_in)
    begin
        if (pull_rstk_in)
        begin
            state_q   <= IDLE;
            carry_q   <= 1'b0;
            decimal_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                IDLE:    if (cmd_start) state_q <= LATCH;
                LATCH:   state_q <= WRITE;
                default: state_q <= IDLE;
            endcase
            if (access & apb_req_i.pwrite & hit_status)
            begin
                carry_q   <= apb_req_i.pwdata[0];
                decimal_q <= apb_req_i.pwdata[1];
            end
            else if (state_q == WRITE && cmd_q.write_carry)
                carry_q <= alu_carry_i;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (cmd_start)
            cmd_q <= alu_cmd_t'(apb_req_i.pwdata);
    end

    always_comb
    begin
        apb_rsp_o.prdata = '0;
        if (hit_status)
            apb_rsp_o.prdata = {30'd0, decimal_q, carry_q};
        else if (hit_reg)
            apb_rsp_o.prdata = reg_off[2] ? rd_word_i[63:32] : rd_word_i[31:0];
        apb_rsp_o.pready  = (state_q == WRITE) | (access & ~hit_cmd_wr);
        apb_rsp_o.pslverr = access & ~hit_cmd_wr & ~hit_status & ~hit_reg;
    end

    assign cmd_o       = cmd_q;
    assign latch_o     = state_q == LATCH;
    assign wr_en_o     = (state_q == WRITE) & cmd_q.write_dst;
    assign decimal_o   = decimal_q;
    assign host_wr_o   = access & apb_req_i.pwrite & hit_reg;
    assign host_hi_o   = reg_off[2];
    assign host_reg_o  = reg_off[4:3];
    assign host_data_o = apb_req_i.pwdata;
    assign rd_sel_o    = (state_q == IDLE) ? reg_off[4:3] : cmd_q.src;  // port A shared with host reads

endmodule

/* design/saturn_bcd_addsub.sv */
// Nibble ripple adder and subtractor, hex or BCD.
// The forced carry enters at the right field nibble; the carry or borrow
// reported is the one leaving the left field nibble.
`timescale 1ns/10ps

module saturn_bcd_addsub
    import alu_pkg::*;
(
    input  word_t    a_i,
    input  word_t    b_i,
    input  logic     sub_i,
    input  logic     dec_i,
    input  logic     forced_carry_i,
    input  nib_idx_t right_i,
    input  nib_idx_t left_i,
    output word_t    q_o,
    output logic     qc_o
);
    logic [NIBBLES:0] c;

    assign c[0] = 1'b0;

    for (genvar n = 0; n < NIBBLES; n++)
    begin : g_nib
        nibble_t    a;
        nibble_t    b;
        logic       cin;
        logic       dec_cy;
        logic [4:0] sum;
        logic [4:0] dif;

        assign a      = a_i[4*n +: 4];
        assign b      = b_i[4*n +: 4];
        assign cin    = c[n] | (forced_carry_i && (right_i == nib_idx_t'(n)));
        assign sum    = {1'b0, a} + {1'b0, b} + {4'd0, cin};
        assign dif    = {1'b0, a} - {1'b0, b} - {4'd0, cin};   // dif[4] is the borrow
        assign dec_cy = sum > 5'd9;

        assign c[n+1] = sub_i ? dif[4] : (dec_i ? dec_cy : sum[4]);
        assign q_o[4*n +: 4] = sub_i ? ((dec_i && dif[4]) ? dif[3:0] + 4'd10 : dif[3:0])
                                     : ((dec_i && dec_cy) ? sum[3:0] + 4'd6 : sum[3:0]);
    end

    assign qc_o = c[{1'b0, left_i} + 5'd1];

endmodule

/* design/saturn_compare.sv */
// Magnitude compare of two nibble strings.
// The most significant differing nibble decides; derived relations
// are formed by the ALU.
`timescale 1ns/10ps

module saturn_compare
    import alu_pkg::*;
(
    input  word_t a_i,
    input  word_t b_i,
    output logic  eq_o,
    output logic  gt_o,
    output logic  lt_o
);
    logic    decided;
    nibble_t na;
    nibble_t nb;

    always_comb
    begin
        decided = 1'b0;
        gt_o    = 1'b0;
        lt_o    = 1'b0;
        na      = '0;
        nb      = '0;
        for (int n = NIBBLES - 1; n >= 0; n--)
        begin
            na = a_i[4*n +: 4];
            nb = b_i[4*n +: 4];
            if (!decided && na != nb)
            begin
                gt_o    = na > nb;
                lt_o    = na < nb;
                decided = 1'b1;
            end
        end
        eq_o = ~decided;
    end

endmodule

/* design/saturn_operand_latch.sv */
// Field mask decode and operand latch in front of the ALU.
// Both operands are zeroed outside the field [right..left] and registered
// on the latch strobe together with the bounds and the effective mode.
`timescale 1ns/10ps

module saturn_operand_latch
    import alu_pkg::*;
(
    input  logic      clk_in,
    input  logic      latch_i,
    input  alu_cmd_t  cmd_i,
    input  logic      decimal_i,
    input  word_t     src_word_i,
    input  word_t     op2_word_i,
    output word_t     src_o,
    output word_t     op2_o,
    output nib_mask_t mask_o,
    output nib_idx_t  left_o,
    output nib_idx_t  right_o,
    output logic      dec_o
);
    nib_mask_t field_mask;
    word_t     op2_word;
    logic      eff_dec;

    function automatic word_t apply_mask(word_t w, nib_mask_t m);
        word_t r;
        for (int n = 0; n < NIBBLES; n++)
            r[4*n +: 4] = m[n] ? w[4*n +: 4] : 4'h0;
        return r;
    endfunction

    assign eff_dec = decimal_i & ~cmd_i.forced_hex;

    // empty when right > left
    always_comb
    begin
        for (int n = 0; n < NIBBLES; n++)
            field_mask[n] = (nib_idx_t'(n) >= cmd_i.right) && (nib_idx_t'(n) <= cmd_i.left);
    end

    always_comb
    begin
        if (cmd_i.op2 == OP2_CONST)
            op2_word = eff_dec ? ALL_NINES : ALL_F;
        else if (!cmd_i.op2[2])
            op2_word = op2_word_i;
        else
            op2_word = '0;   // unused selects read zero
    end

    always_ff @(posedge clk_in)
    begin
        if (latch_i)
        begin
            src_o   <= apply_mask(src_word_i, field_mask);
            op2_o   <= apply_mask(op2_word, field_mask);
            mask_o  <= field_mask;
            left_o  <= cmd_i.left;
            right_o <= cmd_i.right;
            dec_o   <= eff_dec;
        end
    end

endmodule

/* design/saturn_regfile.sv */
// Working registers A to D.
// Two combinational read ports; ALU write-back touches only the nibbles
// enabled in the field mask, host writes replace a whole 32-bit half.
`timescale 1ns/10ps

module saturn_regfile
    import alu_pkg::*, apb_pkg::*;
(
    input  logic      clk_in,
    input  logic      pull_rstk_in,
    input  reg_sel_t  rd_a_sel_i,
    input  reg_sel_t  rd_b_sel_i,
    output word_t     rd_a_o,
    output word_t     rd_b_o,
    input  logic      wr_en_i,
    input  reg_sel_t  wr_sel_i,
    input  nib_mask_t wr_mask_i,
    input  word_t     wr_data_i,
    input  logic      host_wr_i,
    input  logic      host_hi_i,
    input  reg_sel_t  host_reg_i,
    input  apb_data_t host_data_i
);
    word_t regs_q [4];

    always_ff @(posedge clk_in)
    begin
        if (pull_rstk_in)
        begin
            for (int r = 0; r < 4; r++)
                regs_q[r] <= '0;
        end
        else if (wr_en_i)
        begin
            for (int n = 0; n < NIBBLES; n++)
                if (wr_mask_i[n])
                    regs_q[wr_sel_i][4*n +: 4] <= wr_data_i[4*n +: 4];
        end
        else if (host_wr_i)
        begin
            if (host_hi_i)
                regs_q[host_reg_i][63:32] <= host_data_i;
            else
                regs_q[host_reg_i][31:0] <= host_data_i;
        end
    end

    assign rd_a_o = regs_q[rd_a_sel_i];
    assign rd_b_o = regs_q[rd_b_sel_i];

endmodule

/* test/saturn_alru_checker.sv */
// Protocol and sequencing assertions, bound into the top level.
// Checks the APB phase order, pready after reset and the write-back slot.
`timescale 1ns/10ps

module saturn_alru_checker
    import apb_pkg::*;
(
    input logic     clk_in,
    input logic     pull_rstk_in,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input logic     latch_i,
    input logic     wr_en_i
);
    // access phase always preceded by setup
    a_setup_first: assert property (@(posedge clk_in) disable iff (pull_rstk_in)
        $rose(apb_req_i.penable) |-> $past(apb_req_i.psel && !apb_req_i.penable))
        else $error("penable rose without a setup cycle");

    a_ready_reset: assert property (@(posedge clk_in)
        pull_rstk_in |=> !apb_rsp_i.pready)
        else $error("pready high right after reset");

    // write-back only in the completing access cycle after the latch strobe
    a_write_slot: assert property (@(posedge clk_in) disable iff (pull_rstk_in)
        wr_en_i |-> $past(latch_i) && apb_req_i.psel && apb_req_i.penable
                    && apb_rsp_i.pready)
        else $error("register write outside the sequencer WRITE cycle");

endmodule

bind saturn_alru_top saturn_alru_checker u_checker (
    .clk_in       (clk_in),
    .pull_rstk_in (pull_rstk_in),
    .apb_req_i    (apb_req_i),
    .apb_rsp_i    (apb_rsp_o),
    .latch_i      (latch),
    .wr_en_i      (wr_en)
);

/* test/saturn_alru_tb.sv */
// Testbench for the APB-mapped nibble register and arithmetic unit.
// Builds a table of commands with expected results from a nibble model,
// preloads A to C over APB, issues each command and reads C and the status back.
`timescale 1ns/10ps

module saturn_alru_tb
    import alu_pkg::*, apb_pkg::*;
;
    localparam int TIMEOUT = 50;   // cycles per APB transfer

    typedef struct {
        string    name;
        logic     dec;
        alu_cmd_t cmd;
        word_t    a;
        word_t    b;
        word_t    c;
        word_t    exp_word;
        logic     exp_carry;
    } row_t;

    logic     clk_in;
    logic     pull_rstk_in;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    row_t     rows[$];
    integer   seed;

    saturn_alru_top DUT (
        .clk_in       (clk_in),
        .pull_rstk_in (pull_rstk_in),
        .apb_req_i    (apb_req),
        .apb_rsp_o    (apb_rsp)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_carry(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one transfer; setup and access driven on falling edges
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int cnt;
        cnt = 0;
        @(negedge clk_in);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_in);
        apb_req.penable = 1'b1;
        #2;
        while (!apb_rsp.pready)
        begin
            if (cnt == TIMEOUT)
            begin
                $display("APB transfer to address %h got no pready in time", addr);
                $display("Test failed");
                $fatal(1);
            end
            cnt++;
            @(negedge clk_in);
            #2;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk_in);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, wdata, rd, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        apb_xfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic write_reg(input int r, input word_t w);
        apb_write(ADDR_REG_BASE + apb_addr_t'(8 * r), w[31:0]);
        apb_write(ADDR_REG_BASE + apb_addr_t'(8 * r + 4), w[63:32]);
    endtask

    task automatic read_reg(input int r, output word_t w);
        apb_data_t lo;
        apb_data_t hi;
        logic      err;
        apb_read(ADDR_REG_BASE + apb_addr_t'(8 * r), lo, err);
        apb_read(ADDR_REG_BASE + apb_addr_t'(8 * r + 4), hi, err);
        w = {hi, lo};
    endtask

    task automatic rand_word(input logic bcd, output word_t w);
        w = {$random(seed), $random(seed)};
        if (bcd)
            for (int n = 0; n < 16; n++)
                w[4*n +: 4] = 4'($unsigned($random(seed)) % 10);
    endtask

    function automatic alu_cmd_t make_cmd(alu_op_e op, op2_sel_t op2, nib_idx_t l, nib_idx_t r,
                                          logic wd, logic wc, logic fc, logic fh);
        alu_cmd_t c;
        c = '0;
        c.op = op;
        c.src = 2'd0;   // A
        c.op2 = op2;
        c.dst = 2'd2;   // C
        c.left = l;
        c.right = r;
        c.write_dst = wd;
        c.write_carry = wc;
        c.forced_carry = fc;
        c.forced_hex = fh;
        return c;
    endfunction

    // nibble model returning {carry, new C}
    function automatic logic [64:0] model(row_t t);
        nib_mask_t m;
        word_t     s;
        word_t     o;
        word_t     q;
        word_t     res;
        logic      ed;
        logic      cy;
        int        av;
        int        bv;
        int        v;
        int        c;
        ed = t.dec & ~t.cmd.forced_hex;
        cy = 1'b0;
        c  = 0;
        if (t.cmd.op2 == 3'd4)
            o = ed ? 64'h9999999999999999 : 64'hffffffffffffffff;
        else
            o = (t.cmd.op2 == 3'd1) ? t.b : 64'd0;
        for (int n = 0; n < 16; n++)
        begin
            m[n] = (n >= int'(t.cmd.right)) && (n <= int'(t.cmd.left));
            s[4*n +: 4] = m[n] ? t.a[4*n +: 4] : 4'h0;
            o[4*n +: 4] = m[n] ? o[4*n +: 4] : 4'h0;
        end
        q = s;
        case (t.cmd.op)
            ADD, SUB:
                for (int n = 0; n < 16; n++)
                begin
                    av = int'(s[4*n +: 4]);
                    bv = int'(o[4*n +: 4]);
                    if (t.cmd.forced_carry && n == int'(t.cmd.right))
                        c = 1;
                    if (t.cmd.op == SUB)
                    begin
                        v = av - bv - c;
                        c = (v < 0) ? 1 : 0;
                        v = v + (c == 1 ? (ed ? 26 : 16) : 0);
                    end
                    else
                    begin
                        v = av + bv + c;
                        c = (ed ? v > 9 : v > 15) ? 1 : 0;
                        v = v + ((ed && c == 1) ? 6 : 0);
                    end
                    q[4*n +: 4] = 4'(v % 16);
                    if (n == int'(t.cmd.left))
                        cy = (c == 1);
                end
            AND:  q = s & o;
            OR:   q = s | o;
            ANDN: q = s & ~o;
            SL:   q = s << 4;
            SR:   q = s >> 4;
            SRB:  q = s >> 1;
            SLC:  q = (s << 4) | (s >> 60);
            SRC:  q = (s >> 4) | (s << 60);
            EQ:   cy = s == o;
            NEQ:  cy = s != o;
            GT:   cy = s > o;
            GTEQ: cy = s >= o;
            LT:   cy = s < o;
            LTEQ: cy = s <= o;
            default: q = s;
        endcase
        res = t.c;
        if (t.cmd.write_dst)
            for (int n = 0; n < 16; n++)
                if (m[n])
                    res[4*n +: 4] = q[4*n +: 4];
        return {t.cmd.write_carry & cy, res};
    endfunction

    task automatic add_row(input string name, input logic dec, input alu_cmd_t cmd,
                           input word_t a, input word_t b, input word_t c);
        row_t        t;
        logic [64:0] e;
        t.name = name;
        t.dec = dec;
        t.cmd = cmd;
        t.a = a;
        t.b = b;
        t.c = c;
        e = model(t);
        t.exp_word = e[63:0];
        t.exp_carry = e[64];
        rows.push_back(t);
    endtask

    task automatic build_table();
        word_t   x;
        word_t   y;
        word_t   z;
        alu_op_e cmp_ops[6];
        alu_op_e log_ops[8];
        cmp_ops = '{EQ, NEQ, GT, GTEQ, LT, LTEQ};
        log_ops = '{AND, OR, ANDN, SL, SR, SRB, SLC, SRC};
        rand_word(0, x);
        rand_word(0, y);
        rand_word(0, z);
        add_row("hex_add_2_9", 0, make_cmd(ADD, 1, 9, 2, 1, 1, 0, 0), x, y, z);
        rand_word(1, x);
        rand_word(1, y);
        rand_word(0, z);
        add_row("dec_add", 1, make_cmd(ADD, 1, 15, 0, 1, 1, 0, 0), x, y, z);
        add_row("dec_add_fc", 1, make_cmd(ADD, 1, 11, 4, 1, 1, 1, 0), x, y, z);
        add_row("dec_sub", 1, make_cmd(SUB, 1, 15, 0, 1, 1, 0, 0), x, y, z);
        add_row("dec_sub_fc", 1, make_cmd(SUB, 1, 7, 1, 1, 1, 1, 0), y, x, z);
        add_row("dec_add_fhex", 1, make_cmd(ADD, 1, 13, 3, 1, 1, 0, 1), x, y, z);
        for (int i = 0; i < 6; i++)
        begin
            rand_word(0, x);
            rand_word(0, y);
            rand_word(0, z);
            if (x < y)
            begin
                z = x;
                x = y;
                y = z;
            end
            add_row($sformatf("cmp_eq_%s", cmp_ops[i].name()), 0,
                    make_cmd(cmp_ops[i], 1, 15, 0, 0, 1, 0, 0), x, x, z);
            add_row($sformatf("cmp_gt_%s", cmp_ops[i].name()), 0,
                    make_cmd(cmp_ops[i], 1, 15, 0, 0, 1, 0, 0), x, y, z);
            add_row($sformatf("cmp_lt_%s", cmp_ops[i].name()), 0,
                    make_cmd(cmp_ops[i], 1, 15, 0, 0, 1, 0, 0), y, x, z);
        end
        for (int i = 0; i < 8; i++)
        begin
            rand_word(0, x);
            rand_word(0, y);
            rand_word(0, z);
            add_row($sformatf("logic_%s", log_ops[i].name()), 0,
                    make_cmd(log_ops[i], 1, 12, 3, 1, 1, 0, 0), x, y, z);
        end
        rand_word(0, x);
        rand_word(0, z);
        add_row("const_nines", 1, make_cmd(AND, 4, 15, 0, 1, 0, 0, 0), x, y, z);
        add_row("const_all_f", 0, make_cmd(AND, 4, 15, 0, 1, 0, 0, 0), x, y, z);
    endtask

    task automatic run_row(input row_t t);
        apb_data_t st;
        logic      err;
        word_t     got;
        logic      cy0;
        // preset carry opposite to the expected one when the command writes it
        cy0 = t.cmd.write_carry ? ~t.exp_carry : 1'b0;
        apb_write(ADDR_STATUS, {30'd0, t.dec, cy0});
        write_reg(0, t.a);
        write_reg(1, t.b);
        write_reg(2, t.c);
        apb_write(ADDR_CMD, t.cmd);
        read_reg(2, got);
        check_word(t.name, t.exp_word, got);
        apb_read(ADDR_STATUS, st, err);
        check_carry({t.name, " carry"}, t.exp_carry, st[0]);
        check_carry({t.name, " decimal"}, t.dec, st[1]);
    endtask

    initial
    begin
        word_t     w;
        word_t     got;
        apb_data_t rd;
        logic      err;
        seed = 32'h2bbc277f;
        pull_rstk_in = 1'b1;
        apb_req = '0;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        pull_rstk_in = 1'b0;

        for (int r = 0; r < 4; r++)
        begin
            rand_word(0, w);
            write_reg(r, w);
            read_reg(r, got);
            check_word($sformatf("host_reg_%0d", r), w, got);
        end
        apb_read(8'h40, rd, err);
        if (err !== 1'b1)
        begin
            $display("read of unmapped address 0x40 gave no slave error");
            $display("Test failed");
            $fatal(1);
        end

        build_table();
        foreach (rows[i])
            run_row(rows[i]);

        $display("Test passed");
        $finish;
    end

endmodule

/* verilog.f */
design/alu_pkg.sv
design/apb_pkg.sv
design/saturn_apb_ctrl.sv
design/saturn_regfile.sv
design/saturn_operand_latch.sv
design/saturn_bcd_addsub.sv
design/saturn_compare.sv
design/saturn_alu.sv
design/saturn_alru_top.sv
test/saturn_alru_checker.sv
test/saturn_alru_tb.sv
